/* project.f */
hdl/osf_pkg.sv
hdl/osf_if.sv
hdl/osf_config_regs.sv
hdl/oversample_filter.sv
hdl/result_fifo.sv
hdl/result_drain.sv
hdl/osf_top.sv
tb/osf_properties.sv
tb/osf_tb.sv

/* tb/osf_tb.sv */
`default_nettype none

module osf_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import osf_pkg::*;

    // Phase lengths in cycles
    localparam int RESET_CYCLES = 5;
    localparam int N_PASS = 200;
    localparam int N_AVG = 300;
    localparam int N_FWD = 200;
    localparam int N_CLR = 300;
    localparam int N_FLOW = 400;
    localparam int N_CFG = N_CHAN + 3;
    localparam int N_OVF = 60;
    localparam int STIM_CYCLES = RESET_CYCLES + N_PASS + N_AVG + N_FWD + N_CLR
                                 + N_FLOW + 3 * N_CFG + N_OVF;
    localparam int TIMEOUT_CYCLES = STIM_CYCLES + 200;

    logic                 clk_in = 1'b0;
    logic                 sys_rst_in;
    logic                 dv_in;
    chan_t                chan_in;
    sample_t              data_in;
    logic [N_CHAN-1:0]    chan_rst_in;
    logic                 wr_en;
    logic [W_WR_ADDR-1:0] wr_addr;
    chan_t                wr_chan;
    logic [W_WR_DATA-1:0] wr_data;
    logic                 out_valid;
    chan_t                out_chan;
    sample_t              out_data;
    logic                 out_ready;
    logic                 overflow;

    integer  seed;
    int      cycle_count = 0;
    // 0 ready low, 1 ready high, 2 random
    int      ready_mode;
    bit      overflow_ok;
    bit      drop_mode;
    chan_t   last_chan;

    // Reference model state
    int      m_sum   [N_CHAN];
    int      m_cnt   [N_CHAN];
    int      m_ratio [N_CHAN];
    chan_t   exp_chan_q [$];
    sample_t exp_data_q [$];

    osf_top u_osf_top (
        .clk_in      (clk_in),
        .sys_rst_in  (sys_rst_in),
        .dv_in       (dv_in),
        .chan_in     (chan_in),
        .data_in     (data_in),
        .chan_rst_in (chan_rst_in),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_chan     (wr_chan),
        .wr_data     (wr_data),
        .out_valid   (out_valid),
        .out_chan    (out_chan),
        .out_data    (out_data),
        .out_ready   (out_ready),
        .overflow    (overflow)
    );

    always #50 clk_in = ~clk_in;

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1, "run stopped at first error");
    endtask

    function automatic int rand_below(input int n);
        return {$random(seed)} % n;
    endfunction

    // Run limit
    always @(posedge clk_in) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            report_failure($sformatf("timeout, run still busy after %0d cycles",
                                     cycle_count));
        end
    end

    // Output side, values as sampled on this edge
    task automatic check_transfer();
        chan_t   exp_chan;
        sample_t exp_data;
        if (out_valid && out_ready) begin
            assert (exp_data_q.size() != 0)
                else report_failure("output transfer with no result expected");
            exp_chan = exp_chan_q.pop_front();
            exp_data = exp_data_q.pop_front();
            assert (out_chan == exp_chan)
                else report_failure($sformatf("mismatch out_chan: got %h expected %h",
                                              out_chan, exp_chan));
            assert (out_data == exp_data)
                else report_failure($sformatf("mismatch out_data: got %h expected %h",
                                              out_data, exp_data));
        end
        if (!overflow_ok) begin
            assert (overflow == 1'b0)
                else report_failure($sformatf("mismatch overflow: got %h expected %h",
                                              overflow, 1'b0));
        end
    endtask

    // Block mean model, inputs as sampled on this edge
    task automatic update_model();
        int c;
        int v;
        // Clear first, a sample on the same edge starts a new block
        for (int i = 0; i < N_CHAN; i++) begin
            if (chan_rst_in[i]) begin
                m_sum[i] = 0;
                m_cnt[i] = 0;
            end
        end
        if (dv_in) begin
            c = int'(chan_in);
            m_sum[c] = m_sum[c] + int'(data_in);
            m_cnt[c] = m_cnt[c] + 1;
            if (m_cnt[c] == (1 << m_ratio[c])) begin
                if (!drop_mode) begin
                    exp_chan_q.push_back(chan_in);
                    exp_data_q.push_back(sample_t'(m_sum[c] >>> m_ratio[c]));
                end
                m_sum[c] = 0;
                m_cnt[c] = 0;
            end
        end
        // Ratio used from the next sample on
        if (wr_en && (wr_addr == OSF_OS_ADDR)) begin
            v = int'(wr_data[W_OS-1:0]);
            m_ratio[wr_chan] = (v > OS_MAX) ? OS_MAX : v;
        end
    endtask

    // One clock, then default inputs for the next one
    task automatic next_cycle();
        @(posedge clk_in);
        check_transfer();
        update_model();
        dv_in       <= 1'b0;
        chan_rst_in <= '0;
        wr_en       <= 1'b0;
        case (ready_mode)
            0:       out_ready <= 1'b0;
            1:       out_ready <= 1'b1;
            default: out_ready <= (rand_below(2) == 1);
        endcase
    endtask

    task automatic idle(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic drain_results();
        while (exp_data_q.size() != 0) begin
            next_cycle();
        end
    endtask

    task automatic send_one();
        next_cycle();
        dv_in   <= 1'b1;
        chan_in <= chan_t'(rand_below(N_CHAN));
        data_in <= sample_t'($random(seed));
    endtask

    // Ratios for every channel, then all blocks restarted
    task automatic write_config(input bit zero_ratios);
        logic [W_WR_DATA-1:0] val;
        for (int i = 0; i < N_CHAN; i++) begin
            val = zero_ratios ? '0 : W_WR_DATA'($random(seed));
            next_cycle();
            wr_en   <= 1'b1;
            wr_addr <= OSF_OS_ADDR;
            wr_chan <= chan_t'(i);
            wr_data <= val;
        end
        // Address miss, must be ignored
        next_cycle();
        wr_en   <= 1'b1;
        wr_addr <= OSF_OS_ADDR + 8'h01;
        wr_chan <= chan_t'(rand_below(N_CHAN));
        wr_data <= W_WR_DATA'(rand_below(8));
        next_cycle();
        chan_rst_in <= '1;
        next_cycle();
    endtask

    task automatic send_samples(input int n, input int same_pct, input int clr_pct,
                                input bit sparse);
        bit                send;
        logic [N_CHAN-1:0] clr_mask;
        for (int k = 0; k < n; k++) begin
            next_cycle();
            if (sparse) begin
                // Room left for one more result
                send = (exp_data_q.size() < FIFO_DEPTH - 1) && (rand_below(2) == 0);
            end else begin
                send = (rand_below(100) < 80);
            end
            if (rand_below(100) >= same_pct) begin
                last_chan = chan_t'(rand_below(N_CHAN));
            end
            if (send) begin
                dv_in   <= 1'b1;
                chan_in <= last_chan;
                data_in <= sample_t'($random(seed));
            end
            if (rand_below(100) < clr_pct) begin
                clr_mask = '0;
                clr_mask[rand_below(N_CHAN)] = 1'b1;
                chan_rst_in <= clr_mask;
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        seed        = 32'h6ee6_9ee7;
        sys_rst_in  = 1'b1;
        dv_in       = 1'b0;
        chan_in     = '0;
        data_in     = '0;
        chan_rst_in = '0;
        wr_en       = 1'b0;
        wr_addr     = '0;
        wr_chan     = '0;
        wr_data     = '0;
        out_ready   = 1'b0;
        ready_mode  = 1;
        overflow_ok = 1'b0;
        drop_mode   = 1'b0;
        last_chan   = '0;
        for (int i = 0; i < N_CHAN; i++) begin
            m_sum[i]   = 0;
            m_cnt[i]   = 0;
            m_ratio[i] = 0;
        end

        repeat (RESET_CYCLES) @(posedge clk_in);
        sys_rst_in <= 1'b0;
        next_cycle();
        assert (out_valid == 1'b0)
            else report_failure($sformatf("mismatch out_valid: got %h expected %h",
                                          out_valid, 1'b0));

        // Pass-through at reset ratios
        send_samples(N_PASS, 0, 0, 1'b0);
        drain_results();

        // Random ratios, random order, then long same-channel runs
        write_config(1'b0);
        send_samples(N_AVG, 0, 0, 1'b0);
        send_samples(N_FWD, 70, 0, 1'b0);
        drain_results();

        // Channel clears mixed in
        send_samples(N_CLR, 30, 10, 1'b0);
        drain_results();

        // Random back-pressure with sparse input
        write_config(1'b0);
        ready_mode = 2;
        send_samples(N_FLOW, 30, 0, 1'b1);
        drain_results();
        ready_mode = 1;

        // Output stalled until credits run out
        write_config(1'b1);
        ready_mode = 0;
        repeat (FIFO_DEPTH + 1) send_one();
        idle(10);
        overflow_ok = 1'b1;
        drop_mode   = 1'b1;
        repeat (2) send_one();
        while (!overflow) begin
            next_cycle();
        end
        idle(5);
        assert (overflow == 1'b1)
            else report_failure($sformatf("mismatch overflow: got %h expected %h",
                                          overflow, 1'b1));
        ready_mode = 1;
        drain_results();
        // Any late transfer is an extra result
        idle(20);

        if (exp_data_q.size() == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            report_failure($sformatf("%0d expected results never came out",
                                     exp_data_q.size()));
        end
    end

endmodule

`default_nettype wire

/* tb/osf_properties.sv */
`default_nettype none

module osf_properties (
    input  wire                                  clk_in,
    input  wire                                  sys_rst_in,
    input  wire                                  push,
    input  wire  osf_pkg::credit_t               credits,
    input  wire  [$clog2(osf_pkg::FIFO_DEPTH):0] occupancy,
    input  wire                                  out_valid,
    input  wire                                  out_ready,
    input  wire  osf_pkg::sample_t               out_data,
    input  wire                                  overflow
);
    timeunit 1ns;
    timeprecision 1ps;
    import osf_pkg::*;

    // Counter never above the FIFO size
    credit_bound: assert property (@(posedge clk_in) disable iff (sys_rst_in)
        credits <= credit_t'(FIFO_DEPTH))
        else $error("credit counter above FIFO depth");

    // Zero credits means a full FIFO, so every push must find a free slot
    push_has_room: assert property (@(posedge clk_in) disable iff (sys_rst_in)
        push |-> (occupancy < FIFO_DEPTH))
        else $error("push made into a full FIFO");

    // Stalled output keeps its payload
    out_hold: assert property (@(posedge clk_in) disable iff (sys_rst_in)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
        else $error("output changed while stalled");

    // Sticky until reset
    overflow_sticky: assert property (@(posedge clk_in) disable iff (sys_rst_in)
        overflow |=> overflow)
        else $error("overflow cleared without reset");

endmodule

bind osf_top osf_properties u_properties (
    .clk_in     (clk_in),
    .sys_rst_in (sys_rst_in),
    .push       (res_if.push),
    .credits    (u_filter.credits),
    .occupancy  (u_fifo.occupancy),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_data   (out_data),
    .overflow   (overflow)
);

`default_nettype wire

/* hdl/osf_top.sv */
`default_nettype none

module osf_top (
    input  wire                            clk_in,
    input  wire                            sys_rst_in,
    // Sample stream
    input  wire                            dv_in,
    input  wire  osf_pkg::chan_t           chan_in,
    input  wire  osf_pkg::sample_t         data_in,
    // Per-channel accumulation clear
    input  wire  [osf_pkg::N_CHAN-1:0]     chan_rst_in,
    // Register write port
    input  wire                            wr_en,
    input  wire  [osf_pkg::W_WR_ADDR-1:0]  wr_addr,
    input  wire  osf_pkg::chan_t           wr_chan,
    input  wire  [osf_pkg::W_WR_DATA-1:0]  wr_data,
    // Result stream
    output wire                            out_valid,
    output wire  osf_pkg::chan_t           out_chan,
    output wire  osf_pkg::sample_t         out_data,
    input  wire                            out_ready,
    output wire                            overflow
);
    import osf_pkg::*;

    // Ratio codes to the filter
    os_t     os_ratio [N_CHAN];

    // FIFO head into the drain
    logic    head_valid;
    chan_t   head_chan;
    sample_t head_data;

    // Result path and credit return
    osf_if res_if ();

    // ------------------------------------------------------------------------
    // Blocks
    // ------------------------------------------------------------------------
    osf_config_regs u_config_regs (
        .clk_in     (clk_in),
        .sys_rst_in (sys_rst_in),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_chan    (wr_chan),
        .wr_data    (wr_data),
        .os_ratio   (os_ratio)
    );

    oversample_filter u_filter (
        .clk_in      (clk_in),
        .sys_rst_in  (sys_rst_in),
        .chan_rst_in (chan_rst_in),
        .dv_in       (dv_in),
        .chan_in     (chan_in),
        .data_in     (data_in),
        .os_ratio    (os_ratio),
        .res         (res_if.producer),
        .overflow    (overflow)
    );

    result_fifo u_fifo (
        .clk_in     (clk_in),
        .sys_rst_in (sys_rst_in),
        .q          (res_if.buffer),
        .head_valid (head_valid),
        .head_chan  (head_chan),
        .head_data  (head_data)
    );

    result_drain u_drain (
        .clk_in     (clk_in),
        .sys_rst_in (sys_rst_in),
        .q          (res_if.consumer),
        .head_valid (head_valid),
        .head_chan  (head_chan),
        .head_data  (head_data),
        .out_valid  (out_valid),
        .out_chan   (out_chan),
        .out_data   (out_data),
        .out_ready  (out_ready)
    );

endmodule

`default_nettype wire

/* hdl/result_drain.sv */
`default_nettype none

module result_drain (
    input  wire                     clk_in,
    input  wire                     sys_rst_in,
    osf_if.consumer                 q,
    input  wire                     head_valid,
    input  wire  osf_pkg::chan_t    head_chan,
    input  wire  osf_pkg::sample_t  head_data,
    output logic                    out_valid,
    output osf_pkg::chan_t          out_chan,
    output osf_pkg::sample_t        out_data,
    input  wire                     out_ready
);

    // Take the head this cycle
    logic load;

    // Register empty or emptying now
    assign load = head_valid && (!out_valid || out_ready);

    // Each pop frees one slot upstream
    assign q.pop        = load;
    assign q.credit_ret = load;

    // ------------------------------------------------------------------------
    // Output register
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_in) begin
        if (sys_rst_in) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            // Transfer done, nothing behind it
            out_valid <= 1'b0;
        end
    end

    // Payload held until accepted
    always_ff @(posedge clk_in) begin
        if (load) begin
            out_chan <= head_chan;
            out_data <= head_data;
        end
    end

endmodule

`default_nettype wire

/* hdl/result_fifo.sv */
`default_nettype none

module result_fifo (
    input  wire                     clk_in,
    input  wire                     sys_rst_in,
    osf_if.buffer                   q,
    output logic                    head_valid,
    output osf_pkg::chan_t          head_chan,
    output osf_pkg::sample_t        head_data
);
    import osf_pkg::*;

    // Storage, no reset
    chan_t   chan_mem [FIFO_DEPTH];
    sample_t data_mem [FIFO_DEPTH];

    // Pointers wrap naturally
    logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
    // One extra bit to reach full
    logic [$clog2(FIFO_DEPTH):0]   occupancy;

    // ------------------------------------------------------------------------
    // Write side
    // ------------------------------------------------------------------------
    // Credits upstream keep this from overrunning
    always_ff @(posedge clk_in) begin
        if (q.push) begin
            chan_mem[wr_ptr] <= q.push_chan;
            data_mem[wr_ptr] <= q.push_data;
        end
    end

    // ------------------------------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_in) begin
        if (sys_rst_in) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (q.push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (q.pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (sys_rst_in) begin
            occupancy <= '0;
        end else begin
            case ({q.push, q.pop})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Head of queue
    // ------------------------------------------------------------------------
    // Shown without a read delay
    assign head_valid = (occupancy != '0);
    assign head_chan  = chan_mem[rd_ptr];
    assign head_data  = data_mem[rd_ptr];

endmodule

`default_nettype wire

/* hdl/oversample_filter.sv */
`default_nettype none

module oversample_filter (
    input  wire                          clk_in,
    input  wire                          sys_rst_in,
    input  wire  [osf_pkg::N_CHAN-1:0]   chan_rst_in,
    input  wire                          dv_in,
    input  wire  osf_pkg::chan_t         chan_in,
    input  wire  osf_pkg::sample_t       data_in,
    input  wire  osf_pkg::os_t           os_ratio [osf_pkg::N_CHAN],
    osf_if.producer                      res,
    output logic                         overflow
);
    import osf_pkg::*;

    // Per-channel running state
    sum_t    sum_mem   [N_CHAN];
    count_t  count_mem [N_CHAN];

    // Stage 1, fetched operands
    logic    dv_p1;
    chan_t   chan_p1;
    sample_t data_p1;
    sum_t    sum_p1;
    count_t  count_p1;
    os_t     os_p1;

    // Stage 1 arithmetic
    sum_t    acc_sum;
    count_t  acc_count;
    logic    acc_sat;
    sum_t    wb_sum;
    count_t  wb_count;

    // Operands after clear and forwarding
    sum_t    fetch_sum;
    count_t  fetch_count;

    // Stage 2, completed block sums only
    logic    dv_p2;
    chan_t   chan_p2;
    sum_t    sum_p2;
    os_t     os_p2;
    sum_t    mean_p2;

    // Stage 3, result ready for the FIFO
    logic    dv_p3;
    chan_t   chan_p3;
    sample_t data_p3;

    // Free FIFO slots
    credit_t credits;

    // ------------------------------------------------------------------------
    // Accumulate
    // ------------------------------------------------------------------------
    always_comb begin
        // Sign-extend the sample into the sum
        acc_sum   = sum_p1 + sum_t'(data_p1);
        acc_count = count_p1 + count_t'(1);
        // >= covers a ratio lowered mid-block
        acc_sat   = acc_count >= (count_t'(1) << os_p1);
        // Block done, restart from zero
        wb_sum    = acc_sat ? '0 : acc_sum;
        wb_count  = acc_sat ? '0 : acc_count;
    end

    // ------------------------------------------------------------------------
    // Fetch with forwarding
    // ------------------------------------------------------------------------
    always_comb begin
        if (chan_rst_in[chan_in]) begin
            // Clear on this edge wins
            fetch_sum   = '0;
            fetch_count = '0;
        end else if (dv_p1 && (chan_p1 == chan_in)) begin
            // Memory write lands on this same edge
            fetch_sum   = wb_sum;
            fetch_count = wb_count;
        end else begin
            fetch_sum   = sum_mem[chan_in];
            fetch_count = count_mem[chan_in];
        end
    end

    // Pipeline valids
    always_ff @(posedge clk_in) begin
        if (sys_rst_in) begin
            dv_p1 <= 1'b0;
            dv_p2 <= 1'b0;
            dv_p3 <= 1'b0;
        end else begin
            dv_p1 <= dv_in;
            // Only finished blocks go on
            dv_p2 <= dv_p1 && acc_sat;
            dv_p3 <= dv_p2;
        end
    end

    // Pipeline payload
    always_ff @(posedge clk_in) begin
        chan_p1  <= chan_in;
        data_p1  <= data_in;
        sum_p1   <= fetch_sum;
        count_p1 <= fetch_count;
        // Ratio latched with the sample
        os_p1    <= os_ratio[chan_in];

        chan_p2  <= chan_p1;
        sum_p2   <= acc_sum;
        os_p2    <= os_p1;

        chan_p3  <= chan_p2;
        data_p3  <= mean_p2[W_DATA-1:0];
    end

    // Channel state writeback, clears take priority
    always_ff @(posedge clk_in) begin
        for (int i = 0; i < N_CHAN; i++) begin
            if (sys_rst_in || chan_rst_in[i]) begin
                sum_mem[i]   <= '0;
                count_mem[i] <= '0;
            end else if (dv_p1 && (chan_p1 == chan_t'(i))) begin
                sum_mem[i]   <= wb_sum;
                count_mem[i] <= wb_count;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Divide and push
    // ------------------------------------------------------------------------
    // Arithmetic shift keeps the sign
    assign mean_p2 = sum_p2 >>> os_p2;

    // No credit, no push
    assign res.push      = dv_p3 && (credits != '0);
    assign res.push_chan = chan_p3;
    assign res.push_data = data_p3;

    // Credit counter
    always_ff @(posedge clk_in) begin
        if (sys_rst_in) begin
            credits <= credit_t'(FIFO_DEPTH);
        end else begin
            case ({res.push, res.credit_ret})
                2'b10:   credits <= credits - credit_t'(1);
                2'b01:   credits <= credits + credit_t'(1);
                default: credits <= credits;
            endcase
        end
    end

    // Sticky drop flag
    always_ff @(posedge clk_in) begin
        if (sys_rst_in) begin
            overflow <= 1'b0;
        end else if (dv_p3 && (credits == '0)) begin
            overflow <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hdl/osf_config_regs.sv */
`default_nettype none

module osf_config_regs (
    input  wire                            clk_in,
    input  wire                            sys_rst_in,
    input  wire                            wr_en,
    input  wire  [osf_pkg::W_WR_ADDR-1:0]  wr_addr,
    input  wire  osf_pkg::chan_t           wr_chan,
    input  wire  [osf_pkg::W_WR_DATA-1:0]  wr_data,
    output osf_pkg::os_t                   os_ratio [osf_pkg::N_CHAN]
);
    import osf_pkg::*;

    // Raw and clamped ratio code
    os_t  wr_os;
    os_t  wr_os_clamped;
    // Address decode hit
    logic wr_hit;

    // ------------------------------------------------------------------------
    // Write decode
    // ------------------------------------------------------------------------
    // Low bits of the write word only
    assign wr_os = wr_data[W_OS-1:0];

    // Codes above 16x saturate
    assign wr_os_clamped = (wr_os > os_t'(OS_MAX)) ? os_t'(OS_MAX) : wr_os;

    assign wr_hit = wr_en && (wr_addr == OSF_OS_ADDR);

    // ------------------------------------------------------------------------
    // Ratio register bank
    // ------------------------------------------------------------------------
    // New value seen by samples from the next edge on
    always_ff @(posedge clk_in) begin
        if (sys_rst_in) begin
            // All channels back to pass-through
            for (int i = 0; i < N_CHAN; i++) begin
                os_ratio[i] <= '0;
            end
        end else if (wr_hit) begin
            os_ratio[wr_chan] <= wr_os_clamped;
        end
    end

endmodule

`default_nettype wire

/* hdl/osf_if.sv */
`default_nettype none

interface osf_if;
    import osf_pkg::*;

    // Result written into the FIFO
    logic    push;
    chan_t   push_chan;
    sample_t push_data;

    // FIFO read strobe from the drain
    logic    pop;
    // One credit back per freed slot
    logic    credit_ret;

    // Filter side
    modport producer (
        output push,
        output push_chan,
        output push_data,
        input  credit_ret
    );

    // FIFO side, sees both ends
    modport buffer (
        input  push,
        input  push_chan,
        input  push_data,
        input  pop
    );

    // Drain side
    modport consumer (
        output pop,
        output credit_ret
    );

endinterface

`default_nettype wire

/* hdl/osf_pkg.sv */
`default_nettype none

package osf_pkg;

    // ------------------------------------------------------------------------
    // Channel and sample widths
    // ------------------------------------------------------------------------
    // Channels in the multiplexed stream
    localparam int N_CHAN = 8;
    localparam int W_CHAN = 3;
    // Signed ADC sample
    localparam int W_DATA = 18;

    // Encoded log2 ratio
    localparam int W_OS = 3;
    // Largest legal ratio code, 16x
    localparam int OS_MAX = 4;

    // Room for 16 full-scale samples
    localparam int W_SUM = 24;
    // Counts up to 16
    localparam int W_COUNT = 5;

    // ------------------------------------------------------------------------
    // Result buffering and flow control
    // ------------------------------------------------------------------------
    // Must stay a power of two
    localparam int FIFO_DEPTH = 4;
    // Holds 0 to FIFO_DEPTH
    localparam int W_CREDIT = 3;

    // ------------------------------------------------------------------------
    // Write port and address map
    // ------------------------------------------------------------------------
    localparam int W_WR_ADDR = 8;
    localparam int W_WR_DATA = 16;
    // Oversample ratio register
    localparam logic [W_WR_ADDR-1:0] OSF_OS_ADDR = 8'h10;

    // Types
    typedef logic        [W_CHAN-1:0]   chan_t;
    typedef logic signed [W_DATA-1:0]   sample_t;
    typedef logic signed [W_SUM-1:0]    sum_t;
    typedef logic        [W_COUNT-1:0]  count_t;
    typedef logic        [W_OS-1:0]     os_t;
    typedef logic        [W_CREDIT-1:0] credit_t;

endpackage

`default_nettype wire
